//--- verilog/osd_config.svh
// mist-style platform only; aspect defaults are 13-bit and OSD_SND_EN must be 0 or 1
`ifndef OSD_CONFIG_SVH
`define OSD_CONFIG_SVH

// native aspect ratio of the game screen
// horizontal games report ARX:ARY
// vertical games get the pair swapped by the decoder
`define OSD_ARX 13'd4   // numerator
`define OSD_ARY 13'd3   // denominator

// menu sound items
// 1 lets the menu switch the FM and PSG channels off
// 0 keeps both channels on whatever the menu says
`define OSD_SND_EN 1

// menu letters in use by the framework
// O1 flip, O2 rotate control, O34 video mode
// O67 fx volume, O8 psg, O9 fm, OA test, OC pause
// G/H aspect ratio on bits 17:16
// core items start above bit 17

`endif

//--- verilog/osd_status_pkg.sv
// status word layout is the mist one; bits above 17 are left for the core and never decoded
package osd_status_pkg;

    // the host sees the status word as four 16-bit pieces
    localparam int STATUS_WORDS = 4;
    localparam int WORD_BITS    = 16;

    typedef logic [WORD_BITS-1:0] status_word_t;  // one host piece
    typedef logic [1:0]           word_idx_t;     // piece select, 0 is bits 15:0

    // one host write
    typedef struct packed {
        word_idx_t    idx;   // which piece
        status_word_t data;  // new piece value
    } host_wr_t;

    // published menu status
    // bit 1 flip, bit 2 rotate control
    // bits 4:3 video mode, bits 7:6 fx volume
    // bit 8 psg off, bit 9 fm off, bit 10 test
    // bit 12 pause, bits 17:16 aspect select
    typedef logic [STATUS_WORDS*WORD_BITS-1:0] osd_status_t;

    // screen filter, status bits 4:3
    typedef enum logic [1:0] {
        pass_thru     = 2'd0,  // raw pixels
        linear        = 2'd1,  // blend only
        analogue      = 2'd2,  // blend plus old tv colour
        analogue_scan = 2'd3   // as above with scan lines
    } video_mode_e;

endpackage

//--- verilog/osd_cfg_pkg.sv
// decoded groups only; field order is fixed since the change flags compare whole structs
package osd_cfg_pkg;

    typedef logic [12:0] aspect_t;     // hdmi aspect term
    typedef logic [2:0]  scanline_t;   // scan line strength
    typedef logic [1:0]  rotate_t;     // {upside down, rotate 90}
    typedef logic [1:0]  fx_level_t;   // sound effect volume

    // video group
    // any change here pulses video_changed
    typedef struct packed {
        aspect_t   hdmi_arx;     // aspect numerator
        aspect_t   hdmi_ary;     // aspect denominator
        rotate_t   rotate;
        logic      rot_control;  // rotate player controls too
        scanline_t scanlines;    // only 0 or 1 on mist
        logic      bw_en;        // old tv colour filter
        logic      blend_en;     // pixel blending
        logic      en_mixing;
        logic      flip;         // screen flip to the core
    } video_cfg_t;

    // sound group
    // any change here pulses sound_changed
    typedef struct packed {
        logic      enable_fm;
        logic      enable_psg;
        fx_level_t fx_level;     // 2 is the default level
    } sound_cfg_t;

    // core switches
    // all active low towards the core except osd_pause
    typedef struct packed {
        logic dip_pause;   // low halts the game
        logic dip_test;    // low enters service mode
        logic osd_pause;   // menu pause request
    } core_dip_t;

endpackage

//--- verilog/status_loader.sv
// host pieces land in a shadow only; the decoder sees nothing until host_commit copies it over
`timescale 1ns/1ps

module status_loader
    import osd_status_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        host_wr,       // one cycle strobe
    input  host_wr_t    host_wr_data,
    input  logic        host_commit,   // one cycle strobe
    output osd_status_t status
);

    // shadow copy being built by the host
    // piece 0 sits at the bottom so it lines up with status bits 15:0
    status_word_t [STATUS_WORDS-1:0] shadow;

    // host side
    // a write only ever touches its own piece
    always_ff @(posedge clk) begin
        if (rst) begin
            shadow <= '0;
        end else if (host_wr) begin
            shadow[host_wr_data.idx] <= host_wr_data.data;  // other pieces kept
        end
    end

    // publish
    // the shadow is read as it was before this edge
    // so a write in the commit cycle waits for the next commit
    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;  // zero status after reset
        end else if (host_commit) begin
            status <= shadow;  // whole word at once
        end
    end

    // a write strobe with floating data would corrupt a piece silently
    // and only show up one commit later in the decoded groups
    a_wr_data_known: assert property (
        @(posedge clk) disable iff (rst)
        host_wr |-> !$isunknown(host_wr_data)
    ) else $error("host write with unknown data %h", host_wr_data);

endmodule

//--- verilog/dip_decoder.sv
// mist-style decode only; vertical games rotate, scan lines stay at 0 or 1, all outputs registered
`timescale 1ns/1ps

`include "osd_config.svh"

module dip_decoder
    import osd_status_pkg::*;
    import osd_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  osd_status_t status,
    input  logic [6:0]  core_mod,    // bit 0 high for a vertical game
    input  logic        game_pause,
    input  logic        game_test,
    output video_cfg_t  video,
    output sound_cfg_t  sound,
    output core_dip_t   dips
);

    localparam aspect_t ARX    = `OSD_ARX;
    localparam aspect_t ARY    = `OSD_ARY;
    localparam bit      SND_EN = `OSD_SND_EN;

    // video group from the status word
    function automatic video_cfg_t decode_video(osd_status_t s, logic vertical);
        video_cfg_t  v;
        video_mode_e mode;
        logic        tate;
        logic [1:0]  ar;
        v    = '0;
        mode = video_mode_e'(s[4:3]);
        tate = vertical;  // always allowed to rotate here
        ar   = s[17:16];
        case (mode)
            pass_thru: begin
                v.scanlines = 3'd0;
                v.bw_en     = 1'b0;
                v.blend_en  = 1'b0;
            end
            linear: begin
                v.scanlines = 3'd0;
                v.bw_en     = 1'b0;
                v.blend_en  = 1'b1;
            end
            analogue: begin
                v.scanlines = 3'd0;
                v.bw_en     = 1'b1;
                v.blend_en  = 1'b1;
            end
            analogue_scan: begin
                v.scanlines = 3'd1;  // single strength only
                v.bw_en     = 1'b1;
                v.blend_en  = 1'b1;
            end
            default: v.scanlines = 3'd0;
        endcase
        v.en_mixing   = ~s[3];
        v.flip        = ~s[1];     // menu shows flip off as 0
        v.rot_control = s[2];
        v.rotate      = {~v.flip, tate & ~v.rot_control};
        if (ar == 2'd0) begin
            // native ratio, turned on its side for tate
            v.hdmi_arx = vertical ? ARY : ARX;
            v.hdmi_ary = vertical ? ARX : ARY;
        end else begin
            v.hdmi_arx = {11'd0, ar - 2'd1};  // 0, 1 or 2 selects a wide mode
            v.hdmi_ary = '0;
        end
        return v;
    endfunction

    // sound group from the status word
    function automatic sound_cfg_t decode_sound(osd_status_t s);
        sound_cfg_t a;
        a.fx_level   = s[7:6] ^ 2'b10;        // menu 0 means level 2
        a.enable_psg = SND_EN ? ~s[8] : 1'b1;
        a.enable_fm  = SND_EN ? ~s[9] : 1'b1;
        return a;
    endfunction

    // core switches, all active low to the core
    function automatic core_dip_t decode_dips(osd_status_t s, logic pause, logic test);
        core_dip_t d;
        d.osd_pause = s[12];
        d.dip_test  = ~(s[10] | test);   // menu or cabinet button
        d.dip_pause = ~pause;
        return d;
    endfunction

    // one register stage for every field
    // reset loads the decode of a zero status with buttons released
    // core_mod stays live so a vertical game does not see a swap after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            video <= decode_video('0, core_mod[0]);
            sound <= decode_sound('0);
            dips  <= decode_dips('0, 1'b0, 1'b0);
        end else begin
            video <= decode_video(status, core_mod[0]);
            sound <= decode_sound(status);
            dips  <= decode_dips(status, game_pause, game_test);
        end
    end

    // the scaler downstream only has one scan line level on this platform
    a_scanlines_max: assert property (
        @(posedge clk) disable iff (rst)
        video.scanlines <= 3'd1
    ) else $error("scanlines out of range %0d", video.scanlines);

endmodule

//--- verilog/cfg_notifier.sv
// change flags cover the video and sound groups only; a dip change passes through silently
`timescale 1ns/1ps

module cfg_notifier
    import osd_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  video_cfg_t video_in,
    input  sound_cfg_t sound_in,
    input  core_dip_t  dips_in,
    output video_cfg_t video,
    output sound_cfg_t sound,
    output core_dip_t  dips,
    output logic       video_changed,  // high with the new video value
    output logic       sound_changed   // high with the new sound value
);

    // held groups, reloaded every cycle
    always_ff @(posedge clk) begin
        video <= video_in;
        sound <= sound_in;
        dips  <= dips_in;
    end

    // compare against what is held right now
    // the flag lands on the same edge as the new value
    always_ff @(posedge clk) begin
        if (rst) begin
            video_changed <= 1'b0;
            sound_changed <= 1'b0;
        end else begin
            video_changed <= (video_in != video);
            sound_changed <= (sound_in != sound);
        end
    end

    // two flags in a row need two separate input changes
    // otherwise a listener would reload the same settings twice
    a_video_pulse: assert property (
        @(posedge clk) disable iff (rst)
        (video_changed && $past(video_changed)) |-> ($past(video_in) != $past(video_in, 2))
    ) else $error("video_changed held without a new video value");

    a_sound_pulse: assert property (
        @(posedge clk) disable iff (rst)
        (sound_changed && $past(sound_changed)) |-> ($past(sound_in) != $past(sound_in, 2))
    ) else $error("sound_changed held without a new sound value");

endmodule

//--- verilog/osd_settings.sv
// commit to outputs takes three edges and buttons two; host strobes need no handshake
`timescale 1ns/1ps

module osd_settings
    import osd_status_pkg::*;
    import osd_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       host_wr,
    input  host_wr_t   host_wr_data,
    input  logic       host_commit,
    input  logic [6:0] core_mod,
    input  logic       game_pause,
    input  logic       game_test,
    output video_cfg_t video,
    output sound_cfg_t sound,
    output core_dip_t  dips,
    output logic       video_changed,
    output logic       sound_changed
);

    osd_status_t status;      // live word after commit
    video_cfg_t  video_dec;   // decoder to notifier
    sound_cfg_t  sound_dec;
    core_dip_t   dips_dec;

    status_loader status_loader_i (
        .clk          (clk),
        .rst          (rst),
        .host_wr      (host_wr),
        .host_wr_data (host_wr_data),
        .host_commit  (host_commit),
        .status       (status)
    );

    dip_decoder dip_decoder_i (
        .clk        (clk),
        .rst        (rst),
        .status     (status),
        .core_mod   (core_mod),
        .game_pause (game_pause),  // straight from the cabinet
        .game_test  (game_test),
        .video      (video_dec),
        .sound      (sound_dec),
        .dips       (dips_dec)
    );

    cfg_notifier cfg_notifier_i (
        .clk           (clk),
        .rst           (rst),
        .video_in      (video_dec),
        .sound_in      (sound_dec),
        .dips_in       (dips_dec),
        .video         (video),
        .sound         (sound),
        .dips          (dips),
        .video_changed (video_changed),
        .sound_changed (sound_changed)
    );

endmodule

//--- tests/osd_settings_tb.sv
// random host traffic checked every cycle against a model; core_mod must stay put during reset
`timescale 1ns/1ps

`include "osd_config.svh"

module osd_settings_tb
    import osd_status_pkg::*;
    import osd_cfg_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 16;
    localparam int LOAD_CYCLES = 10;  // four pieces, commit, five to settle
    localparam int N_MODES     = 32;  // 4 filters x 4 aspects x 2 orientations
    localparam int N_SOUND     = 20;
    localparam int N_BTN       = 30;
    localparam int N_QUIET     = 12;
    localparam int N_VID       = 12;
    localparam int PLAN_CYCLES = RST_CYCLES + 40
        + (N_MODES + N_SOUND + 2 + N_QUIET + N_VID) * LOAD_CYCLES + 2 * N_BTN;
    localparam int MARGIN      = 200;

    // decoded field positions in the status word
    localparam osd_status_t VID_MASK = 64'h0000_0000_0003_001e;  // 1..4, 17:16
    localparam osd_status_t SND_MASK = 64'h0000_0000_0000_03c0;  // 9:6
    localparam osd_status_t DIP_MASK = 64'h0000_0000_0000_1400;  // 10, 12
    localparam osd_status_t OUT_MASK = 64'hffff_ffff_fffc_e821;  // never decoded

    logic        clk;
    logic        rst;
    logic        host_wr;
    host_wr_t    host_wr_data;
    logic        host_commit;
    logic [6:0]  core_mod;
    logic        game_pause;
    logic        game_test;
    video_cfg_t  video;
    sound_cfg_t  sound;
    core_dip_t   dips;
    logic        video_changed;
    logic        sound_changed;

    integer      seed;
    logic        checking;      // per-cycle compare on
    osd_status_t tb_shadow;     // what the host has written
    osd_status_t committed;     // what the last commit published

    // model state
    osd_status_t m_shadow, m_status;
    video_cfg_t  m_vid_d, m_vid_o;
    sound_cfg_t  m_snd_d, m_snd_o;
    core_dip_t   m_dip_d, m_dip_o;
    logic        m_vchg, m_schg;

    osd_settings osd_settings_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected video group from the menu rules
    function automatic video_cfg_t exp_video(osd_status_t s, logic vert);
        video_cfg_t v;
        v             = '0;
        v.blend_en    = (s[4:3] != 2'd0);        // every filter but pass_thru
        v.bw_en       = s[4];                    // analogue and analogue_scan
        v.scanlines   = (s[4:3] == 2'd3) ? 3'd1 : 3'd0;
        v.en_mixing   = !s[3];
        v.flip        = !s[1];
        v.rot_control = s[2];
        v.rotate[1]   = s[1];                    // inverse of flip
        v.rotate[0]   = vert && !s[2];
        if (s[17:16] == 2'd0) begin
            v.hdmi_arx = vert ? `OSD_ARY : `OSD_ARX;  // tate swap
            v.hdmi_ary = vert ? `OSD_ARX : `OSD_ARY;
        end else begin
            v.hdmi_arx = {11'd0, s[17:16]} - 13'd1;
            v.hdmi_ary = 13'd0;
        end
        return v;
    endfunction

    function automatic sound_cfg_t exp_sound(osd_status_t s);
        sound_cfg_t a;
        logic       en;
        en           = (`OSD_SND_EN != 0);
        a.fx_level   = {!s[7], s[6]};
        a.enable_psg = en ? !s[8] : 1'b1;
        a.enable_fm  = en ? !s[9] : 1'b1;
        return a;
    endfunction

    function automatic core_dip_t exp_dips(osd_status_t s, logic pause, logic test);
        core_dip_t d;
        d.osd_pause = s[12];
        d.dip_test  = !(s[10] || test);
        d.dip_pause = !pause;
        return d;
    endfunction

    // model pipeline through loader, decoder and notifier
    always @(posedge clk) begin
        if (rst) begin
            m_shadow <= '0;
            m_status <= '0;
            m_vid_d  <= exp_video('0, core_mod[0]);
            m_snd_d  <= exp_sound('0);
            m_dip_d  <= exp_dips('0, 1'b0, 1'b0);
            m_vchg   <= 1'b0;
            m_schg   <= 1'b0;
        end else begin
            if (host_wr)
                m_shadow[host_wr_data.idx * 16 +: 16] <= host_wr_data.data;
            if (host_commit)
                m_status <= m_shadow;  // old shadow while the write waits
            m_vid_d <= exp_video(m_status, core_mod[0]);
            m_snd_d <= exp_sound(m_status);
            m_dip_d <= exp_dips(m_status, game_pause, game_test);
            m_vchg  <= (m_vid_d != m_vid_o);
            m_schg  <= (m_snd_d != m_snd_o);
        end
        m_vid_o <= m_vid_d;  // held stage
        m_snd_o <= m_snd_d;
        m_dip_o <= m_dip_d;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_video(input string name, input video_cfg_t got, input video_cfg_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_sound(input string name, input sound_cfg_t got, input sound_cfg_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_dips(input string name, input core_dip_t got, input core_dip_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("mismatch at %0t: %s pulses got %0d expected %0d",
                                $time, name, got, exp));
    endtask

    // compare every cycle after reset while outputs are stable
    always @(negedge clk) begin
        if (checking) begin
            check_video("video", video, m_vid_o);
            check_sound("sound", sound, m_snd_o);
            check_dips("dips", dips, m_dip_o);
            check_flag("video_changed", video_changed, m_vchg);
            check_flag("sound_changed", sound_changed, m_schg);
        end
    end

    initial begin
        #((PLAN_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: run went past the planned number of cycles");
        $display("Test failed");
        $fatal(1);
    end

    // all stimulus tasks start and end on a falling edge
    task automatic host_write(input word_idx_t idx, input status_word_t data);
        host_wr           = 1'b1;
        host_wr_data.idx  = idx;
        host_wr_data.data = data;
        tb_shadow[idx * 16 +: 16] = data;
        @(negedge clk);
        host_wr      = 1'b0;
        host_wr_data = '0;
    endtask

    task automatic commit_host(input logic with_wr, input word_idx_t idx, input status_word_t data);
        host_commit = 1'b1;
        committed   = tb_shadow;  // pre-write shadow gets published
        if (with_wr) begin
            host_wr           = 1'b1;
            host_wr_data.idx  = idx;
            host_wr_data.data = data;
            tb_shadow[idx * 16 +: 16] = data;
        end
        @(negedge clk);
        host_commit  = 1'b0;
        host_wr      = 1'b0;
        host_wr_data = '0;
    endtask

    task automatic count_pulses(input int n, output int vc, output int sc);
        vc = 0;
        sc = 0;
        repeat (n) begin
            @(negedge clk);
            if (video_changed)
                vc++;
            if (sound_changed)
                sc++;
        end
    endtask

    // full word in then commit and count what came out
    task automatic load_status(input osd_status_t s, output int vc, output int sc);
        for (int i = 0; i < STATUS_WORDS; i++)
            host_write(word_idx_t'(i), s[i * 16 +: 16]);
        commit_host(1'b0, 2'd0, 16'd0);
        count_pulses(5, vc, sc);
    endtask

    task automatic load_and_expect(input osd_status_t s, input int ev, input int es);
        int vc;
        int sc;
        load_status(s, vc, sc);
        check_count("video_changed", vc, ev);
        check_count("sound_changed", sc, es);
    endtask

    initial begin
        video_cfg_t   v0;
        osd_status_t  s;
        osd_status_t  old;
        logic [31:0]  r;
        int           vc;
        int           sc;
        seed         = 32'h664b727c;
        checking     = 1'b0;
        rst          = 1'b1;
        host_wr      = 1'b0;
        host_wr_data = '0;
        host_commit  = 1'b0;
        core_mod     = 7'd0;  // horizontal game
        game_pause   = 1'b0;
        game_test    = 1'b0;
        tb_shadow    = '0;
        committed    = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst      = 1'b0;
        checking = 1'b1;

        // zero status decode with literal values
        v0 = '0;
        v0.hdmi_arx  = 13'd4;
        v0.hdmi_ary  = 13'd3;
        v0.flip      = 1'b1;
        v0.en_mixing = 1'b1;
        check_video("video", video, v0);
        check_sound("sound", sound, '{enable_fm: 1'b1, enable_psg: 1'b1, fx_level: 2'd2});
        check_dips("dips", dips, '{dip_pause: 1'b1, dip_test: 1'b1, osd_pause: 1'b0});
        count_pulses(4, vc, sc);
        check_count("video_changed", vc, 0);
        check_count("sound_changed", sc, 0);

        // writes alone must not reach the outputs
        repeat (8) begin
            r = $random(seed);
            host_write(r[17:16], r[15:0]);
            check_video("video", video, exp_video(committed, core_mod[0]));
            check_sound("sound", sound, exp_sound(committed));
            check_dips("dips", dips, exp_dips(committed, game_pause, game_test));
        end
        // write in the commit cycle is held back
        commit_host(1'b1, 2'd0, tb_shadow[15:0] ^ 16'h001e);
        repeat (4) @(negedge clk);
        check_video("video", video, exp_video(committed, core_mod[0]));
        check_sound("sound", sound, exp_sound(committed));
        old = committed;
        commit_host(1'b0, 2'd0, 16'd0);
        count_pulses(5, vc, sc);
        check_count("video_changed", vc, (exp_video(committed, 1'b0) != exp_video(old, 1'b0)));
        check_video("video", video, exp_video(committed, core_mod[0]));

        // filters, aspects and orientation
        for (int m = 0; m < 4; m++) begin
            for (int a = 0; a < 4; a++) begin
                for (int t = 0; t < 2; t++) begin
                    r        = $random(seed);
                    core_mod = {r[6:1], t[0]};
                    s        = {$random(seed), $random(seed)};
                    s[4:3]   = m[1:0];
                    s[17:16] = a[1:0];
                    load_status(s, vc, sc);
                end
            end
        end
        core_mod = 7'd0;
        repeat (3) @(negedge clk);

        // sound bits only
        repeat (N_SOUND) begin
            old = committed;
            s   = old ^ ({$random(seed), $random(seed)} & SND_MASK);
            load_and_expect(s, 0, (exp_sound(s) != exp_sound(old)));
        end

        // buttons against s[10] with no flags from dips alone
        for (int k = 0; k < 2; k++) begin
            s     = committed & ~DIP_MASK;
            r     = $random(seed);
            s[10] = k[0];
            s[12] = r[0];
            load_and_expect(s, 0, 0);
            vc = 0;
            sc = 0;
            repeat (N_BTN) begin
                r          = $random(seed);
                game_pause = r[0];
                game_test  = r[1];
                @(negedge clk);
                if (video_changed)
                    vc++;
                if (sound_changed)
                    sc++;
            end
            check_count("video_changed", vc, 0);
            check_count("sound_changed", sc, 0);
        end
        game_pause = 1'b0;
        game_test  = 1'b0;

        // undecoded bits stay quiet
        repeat (N_QUIET) begin
            s = committed ^ ({$random(seed), $random(seed)} & OUT_MASK);
            load_and_expect(s, 0, 0);
        end

        // video bits only with flip always toggled
        repeat (N_VID) begin
            s    = committed ^ ({$random(seed), $random(seed)} & VID_MASK);
            s[1] = ~committed[1];
            load_and_expect(s, 1, 0);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/osd_status_pkg.sv
verilog/osd_cfg_pkg.sv
verilog/status_loader.sv
verilog/dip_decoder.sv
verilog/cfg_notifier.sv
verilog/osd_settings.sv
tests/osd_settings_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; status follows the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f files.f \
        --top-module osd_settings_tb -o osd_settings_sim \
    && ./obj_dir/osd_settings_sim | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
